/* compile.f */
src/soc_pkg.sv
src/addr_decoder.sv
src/mem_bank.sv
src/bus_return.sv
src/soc_top.sv
tb/tb_soc.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the bus fabric testbench with Verilator

set -u

cd "$(dirname "$0")" || exit 1

TOP=tb_soc
BUILD_DIR=obj_dir
LOG=sim.log

if ! command -v verilator > /dev/null 2>&1; then
  echo "verilator is not on the PATH"
  exit 1
fi

verilator --binary --timing --assert \
  -f compile.f \
  --top-module "$TOP" \
  -Mdir "$BUILD_DIR" \
  -o "sim_$TOP"
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

"./$BUILD_DIR/sim_$TOP" 2>&1 | tee "$LOG"
status=${PIPESTATUS[0]}
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "SIMULATION FAILED" "$LOG"; then
  echo "testbench reported a failure, see $LOG"
  exit 1
fi

echo "run finished, log in $LOG"
exit 0

/* tb/soc_stim.txt */
# columns: test op addr wdat be exp_rdat exp_err
# addr, wdat, be and exp_rdat in hex, exp_err is 0 or 1
1 W 00800000 11111111 f 00000000 0
1 R 00800000 00000000 0 11111111 0
1 W 00800804 22222222 f 00000000 0
1 R 00800804 00000000 0 22222222 0
1 W 00801008 33333333 f 00000000 0
1 R 00801008 00000000 0 33333333 0
1 W 00801ffc 44444444 f 00000000 0
1 R 00801ffc 00000000 0 44444444 0
2 W 00800010 aabbccdd f 00000000 0
2 W 00800010 11223344 1 00000000 0
2 R 00800010 00000000 0 aabbcc44 0
2 W 00800010 55667788 6 00000000 0
2 R 00800010 00000000 0 aa667744 0
2 W 00800810 01020304 f 00000000 0
2 W 00800810 f0e0d0c0 a 00000000 0
2 R 00800810 00000000 0 f002d004 0
2 W 00800010 00000000 0 00000000 0
2 R 00800010 00000000 0 aa667744 0
3 W 00800020 a0a0a0a0 f 00000000 0
3 W 00800820 b1b1b1b1 f 00000000 0
3 W 00801020 c2c2c2c2 f 00000000 0
3 W 00801820 d3d3d3d3 f 00000000 0
3 R 00800020 00000000 0 a0a0a0a0 0
3 R 00800820 00000000 0 b1b1b1b1 0
3 R 00801020 00000000 0 c2c2c2c2 0
3 R 00801820 00000000 0 d3d3d3d3 0
3 W 008007fc 0badf00d f 00000000 0
3 W 00800800 600dcafe f 00000000 0
3 R 008007fc 00000000 0 0badf00d 0
3 R 00800800 00000000 0 600dcafe 0
4 W 007ffffc deadbeef f 00000000 1
4 R 007ffffc 00000000 0 00000000 1
4 W 00802000 deadbeef f 00000000 1
4 R 00000000 00000000 0 00000000 1
4 W fffffffc 12345678 f 00000000 1
4 R 00800000 00000000 0 11111111 0
4 R 008007fc 00000000 0 0badf00d 0
5 W 00800030 5a5a5a5a f 00000000 0
5 R 00800030 00000000 0 5a5a5a5a 0
5 W 00801034 3c3c3c3c f 00000000 0
5 R 00801034 00000000 0 3c3c3c3c 0
5 W 00802004 ffffffff f 00000000 1
5 R 00800030 00000000 0 5a5a5a5a 0

/* tb/tb_soc.sv */
`timescale 1ns/1ps

module tb_soc import soc_pkg::*; ();

  localparam int          DRIVE_DLY    = 1;
  localparam int          RESET_CYCLES = 4;
  localparam int          HOLD_TEST    = 5;
  localparam int          LFSR_TEST    = 6;
  localparam int          LFSR_BANK    = 3;
  localparam logic [31:0] LFSR_SEED    = 32'h5dae;
  localparam string       STIM_FILE    = "tb/soc_stim.txt";

  // one bus operation from the stimulus file
  typedef struct {
    int    test_no;
    logic  we;
    addr_t adr;
    data_t wdat;
    be_t   be;
    data_t exp_rdat;
    logic  exp_err;
  } stim_line_t;

  logic     sysclock;
  logic     rst_n;
  bus_req_t bus_req;
  bus_rsp_t bus_rsp;

  stim_line_t  stim_q [$];
  data_t       model_mem [NUM_BANKS][BANK_WORDS];
  logic [31:0] lfsr_q;

  int cycle_cnt    = 0;
  int cycle_limit  = 1000000;
  int total_checks = 0;
  int total_errors = 0;
  int test_checks  = 0;
  int test_errors  = 0;

  soc_top dut_i (
    .sysclock  (sysclock),
    .rst_n     (rst_n),
    .bus_req_i (bus_req),
    .bus_rsp_o (bus_rsp)
  );

  initial sysclock = 1'b0;
  always #5 sysclock = ~sysclock;

  // watchdog against a missing ack
  always @(posedge sysclock) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt >= cycle_limit) begin
      $display("timeout: ack never arrived within %0d cycles", cycle_limit);
      $display("SIMULATION FAILED");
      $finish;
    end
  end

  // taps for x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
  endfunction

  // one lfsr step per data bit
  task automatic random_word(output data_t w);
    w = '0;
    for (int i = 0; i < DATA_W; i++) begin
      lfsr_q = lfsr_step(lfsr_q);
      w = {w[DATA_W-2:0], lfsr_q[0]};
    end
  endtask

  // bank and word of an address, 0 when outside every bank
  function automatic bit map_address(input addr_t adr, output int bank, output int word);
    addr_t off;
    bank = 0;
    word = 0;
    if (adr < BANK_BASE) begin
      return 1'b0;
    end
    off = adr - BANK_BASE;
    if (off >= addr_t'(NUM_BANKS) * BANK_STRIDE) begin
      return 1'b0;
    end
    bank = int'(off / BANK_STRIDE);
    word = int'((off % BANK_STRIDE) >> 2);
    return 1'b1;
  endfunction

  task automatic model_write(input int bank, input int word, input data_t wdat, input be_t be);
    for (int b = 0; b < BE_W; b++) begin
      if (be[b]) begin
        model_mem[bank][word][8*b +: 8] = wdat[8*b +: 8];
      end
    end
  endtask

  function automatic string test_name(input int t);
    case (t)
      1:       return "full word write and read per bank";
      2:       return "partial byte enables";
      3:       return "bank separation";
      4:       return "unmapped accesses";
      5:       return "ack timing with held cyc";
      6:       return "lfsr fill of bank 3";
      default: return "unknown";
    endcase
  endfunction

  task automatic count_check();
    total_checks++;
    test_checks++;
  endtask

  task automatic report_error(input string msg);
    total_errors++;
    test_errors++;
    $display("[ERROR] %0t: %s", $time, msg);
  endtask

  task automatic finish_test(input int t);
    $display("test %0d (%s): %0d checks, %0d errors, %s", t, test_name(t),
             test_checks, test_errors, (test_errors == 0) ? "pass" : "fail");
    test_checks = 0;
    test_errors = 0;
  endtask

  // one request, waits for ack and counts edges until it shows up
  task automatic bus_access(input logic we, input addr_t adr, input data_t wdat,
                            input be_t be, input bit hold, output data_t rdat,
                            output logic err, output int lat);
    @(posedge sysclock);
    #DRIVE_DLY;
    bus_req.cyc  = 1'b1;
    bus_req.we   = we;
    bus_req.adr  = adr;
    bus_req.wdat = wdat;
    bus_req.be   = be;
    // ack is looked at on falling edges, one rising edge per count
    lat = 0;
    @(negedge sysclock);
    while (bus_rsp.ack !== 1'b1) begin
      lat++;
      @(negedge sysclock);
    end
    rdat = bus_rsp.rdat;
    err  = bus_rsp.err;
    if (hold) begin
      // a second write here would store the inverted word
      @(posedge sysclock);
      #DRIVE_DLY;
      bus_req.wdat = ~wdat;
      @(negedge sysclock);
      count_check();
      if (bus_rsp.ack !== 1'b0) begin
        report_error($sformatf("second ack for %h while cyc held", adr));
      end
    end
    @(posedge sysclock);
    #DRIVE_DLY;
    bus_req = '0;
  endtask

  task automatic check_access(input stim_line_t s, input bit hold);
    data_t rdat;
    data_t exp_word;
    logic  err;
    int    lat;
    int    bank;
    int    word;
    bit    mapped;
    bus_access(s.we, s.adr, s.wdat, s.be, hold, rdat, err, lat);
    mapped = map_address(s.adr, bank, word);
    count_check();
    if (lat != 1) begin
      report_error($sformatf("ack for %h came %0d cycles after cyc, expected 1", s.adr, lat));
    end
    count_check();
    if (s.exp_err !== !mapped) begin
      report_error($sformatf("stim err column for %h disagrees with the map", s.adr));
    end
    count_check();
    if (err !== !mapped) begin
      report_error($sformatf("err for %h is %b, expected %b", s.adr, err, !mapped));
    end
    if (s.we) begin
      if (mapped) begin
        model_write(bank, word, s.wdat, s.be);
      end
      count_check();
      if (rdat !== '0) begin
        report_error($sformatf("write to %h returned rdat %h", s.adr, rdat));
      end
    end else begin
      exp_word = mapped ? model_mem[bank][word] : '0;
      count_check();
      if (exp_word !== s.exp_rdat) begin
        report_error($sformatf("model word %h differs from stim value %h at %h",
                               exp_word, s.exp_rdat, s.adr));
      end
      count_check();
      if (rdat !== exp_word) begin
        report_error($sformatf("read of %h gave %h, expected %h", s.adr, rdat, exp_word));
      end
    end
  endtask

  task automatic load_stimulus(output bit ok);
    int          fd;
    int          rc;
    int          test_no;
    int          err_col;
    string       line;
    string       op;
    logic [31:0] adr;
    logic [31:0] wdat;
    logic [31:0] be;
    logic [31:0] rdat;
    stim_line_t  s;
    ok = 1'b1;
    fd = $fopen(STIM_FILE, "r");
    if (fd == 0) begin
      $display("cannot open stimulus file %s", STIM_FILE);
      ok = 1'b0;
      return;
    end
    while (!$feof(fd)) begin
      line = "";
      rc = $fgets(line, fd);
      // comment lines start with a hash
      if (rc > 0 && line.getc(0) != "#") begin
        rc = $sscanf(line, "%d %s %h %h %h %h %d", test_no, op, adr, wdat, be, rdat, err_col);
        if (rc == 7 && (op == "W" || op == "R")) begin
          s.test_no  = test_no;
          s.we       = (op == "W");
          s.adr      = adr;
          s.wdat     = wdat;
          s.be       = be[BE_W-1:0];
          s.exp_rdat = rdat;
          s.exp_err  = err_col[0];
          stim_q.push_back(s);
        end else if (rc > 0) begin
          $display("stimulus line not understood: %s", line);
          ok = 1'b0;
        end
      end
    end
    $fclose(fd);
    if (stim_q.size() == 0) begin
      $display("stimulus file holds no bus operations");
      ok = 1'b0;
    end
  endtask

  task automatic run_all();
    int         cur;
    data_t      d;
    stim_line_t s;
    repeat (RESET_CYCLES) @(posedge sysclock);
    #DRIVE_DLY;
    rst_n = 1'b1;
    @(negedge sysclock);
    count_check();
    if (bus_rsp !== '0) begin
      report_error($sformatf("outputs not idle after reset: ack %b err %b rdat %h",
                             bus_rsp.ack, bus_rsp.err, bus_rsp.rdat));
    end

    cur = stim_q[0].test_no;
    foreach (stim_q[i]) begin
      if (stim_q[i].test_no != cur) begin
        finish_test(cur);
        cur = stim_q[i].test_no;
      end
      check_access(stim_q[i], stim_q[i].test_no == HOLD_TEST);
    end
    finish_test(cur);

    // fill every word of one bank, then read it all back
    lfsr_q = LFSR_SEED;
    s.test_no = LFSR_TEST;
    s.be      = '1;
    s.exp_err = 1'b0;
    for (int w = 0; w < BANK_WORDS; w++) begin
      random_word(d);
      s.we       = 1'b1;
      s.adr      = BANK_BASE + addr_t'(LFSR_BANK) * BANK_STRIDE + addr_t'(w) * 4;
      s.wdat     = d;
      s.exp_rdat = '0;
      check_access(s, 1'b0);
    end
    // replay the same sequence for the expected words
    lfsr_q = LFSR_SEED;
    for (int w = 0; w < BANK_WORDS; w++) begin
      random_word(d);
      s.we       = 1'b0;
      s.adr      = BANK_BASE + addr_t'(LFSR_BANK) * BANK_STRIDE + addr_t'(w) * 4;
      s.wdat     = '0;
      s.exp_rdat = d;
      check_access(s, 1'b0);
    end
    finish_test(LFSR_TEST);

    $display("all tests done: %0d checks, %0d errors", total_checks, total_errors);
    if (total_errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  endtask

  initial begin
    bit ok;
    rst_n   = 1'b0;
    bus_req = '0;
    lfsr_q  = LFSR_SEED;
    load_stimulus(ok);
    // four cycles per operation leaves room for the held-cyc ones
    cycle_limit = (stim_q.size() + 2 * BANK_WORDS) * 4 + 20;
    if (!ok) begin
      $display("stimulus could not be loaded");
      $display("SIMULATION FAILED");
      $finish;
    end else begin
      run_all();
    end
  end

endmodule

/* src/soc_top.sv */
`timescale 1ns/1ps

module soc_top import soc_pkg::*; (
  input  logic      sysclock,
  input  logic      rst_n,
  input  bus_req_t  bus_req_i,
  output bus_rsp_t  bus_rsp_o
);

  csel_t                  csel;
  word_adr_t              word_adr;
  logic [NUM_BANKS-1:0]   bank_sel;
  bank_rsp_t              bank_rsp [NUM_BANKS];

  // address map
  addr_decoder u_decoder (
    .req_i      (bus_req_i),
    .csel_o     (csel),
    .bank_sel_o (bank_sel),
    .word_adr_o (word_adr)
  );

  // onboard memory banks, one per chipselect
  for (genvar i = 0; i < NUM_BANKS; i++) begin : g_bank
    mem_bank u_bank (
      .sysclock   (sysclock),
      .rst_n      (rst_n),
      .req_i      (bus_req_i),
      .sel_i      (bank_sel[i]),
      .word_adr_i (word_adr),
      .rsp_o      (bank_rsp[i])
    );
  end

  // response mux and fault answer
  bus_return u_return (
    .sysclock   (sysclock),
    .rst_n      (rst_n),
    .req_i      (bus_req_i),
    .csel_i     (csel),
    .bank_rsp_i (bank_rsp),
    .rsp_o      (bus_rsp_o)
  );

endmodule

/* src/bus_return.sv */
`timescale 1ns/1ps

module bus_return import soc_pkg::*; (
  input  logic       sysclock,
  input  logic       rst_n,
  input  bus_req_t   req_i,
  input  csel_t      csel_i,
  input  bank_rsp_t  bank_rsp_i [NUM_BANKS],
  output bus_rsp_t   rsp_o
);

  logic  bank_ack;
  data_t bank_rdat;
  logic  fault_req;
  logic  fault_ack_q;
  logic  fault_busy_q;

  // OR together the answer of the selected bank only
  always_comb begin
    bank_ack  = 1'b0;
    bank_rdat = '0;
    for (int i = 0; i < NUM_BANKS; i++) begin
      if (csel_i == csel_t'(i + 1)) begin
        bank_ack  = bank_ack | bank_rsp_i[i].ack;
        bank_rdat = bank_rdat | bank_rsp_i[i].rdat;
      end
    end
  end

  // unmapped access, answered here with an error
  assign fault_req = req_i.cyc && (csel_i == CSEL_NONE);

  always_ff @(posedge sysclock or negedge rst_n) begin
    if (!rst_n) begin
      fault_ack_q  <= 1'b0;
      fault_busy_q <= 1'b0;
    end else begin
      fault_ack_q  <= fault_req && !fault_ack_q && !fault_busy_q;
      // stays set while the master keeps cyc up after the ack
      fault_busy_q <= fault_req && (fault_ack_q || fault_busy_q);
    end
  end

  assign rsp_o.ack  = bank_ack | fault_ack_q;
  assign rsp_o.err  = fault_ack_q;
  // read data only on a mapped read ack
  assign rsp_o.rdat = (bank_ack && !req_i.we) ? bank_rdat : '0;

  // a mapped request never reports a fault
  assert property (@(posedge sysclock) disable iff (!rst_n)
                   (req_i.cyc && (csel_i != CSEL_NONE)) |-> !(rsp_o.ack && rsp_o.err))
    else $error("bus_return: err with mapped chipselect %0d", csel_i);

endmodule

/* src/mem_bank.sv */
`timescale 1ns/1ps

module mem_bank import soc_pkg::*; (
  input  logic       sysclock,
  input  logic       rst_n,
  input  bus_req_t   req_i,
  input  logic       sel_i,
  input  word_adr_t  word_adr_i,
  output bank_rsp_t  rsp_o
);

  // access handshake per request
  typedef enum logic [1:0] {
    ST_IDLE,
    ST_ACK,
    ST_HOLD
  } bank_state_t;

  bank_state_t state_q;
  bank_state_t state_d;

  data_t mem [BANK_WORDS];
  data_t rdat_q;
  logic  access;
  logic  ack;

  // only a fresh select starts an access
  assign access = sel_i && (state_q == ST_IDLE);

  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_IDLE: begin
        if (sel_i) begin
          state_d = ST_ACK;
        end
      end
      ST_ACK: begin
        // master normally still holds cyc at this edge
        state_d = sel_i ? ST_HOLD : ST_IDLE;
      end
      ST_HOLD: begin
        // wait for cyc to drop before a new access
        if (!sel_i) begin
          state_d = ST_IDLE;
        end
      end
      default: state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge sysclock or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= ST_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // storage and read register, read sees the old contents
  always_ff @(posedge sysclock) begin
    if (access) begin
      if (req_i.we) begin
        for (int b = 0; b < BE_W; b++) begin
          if (req_i.be[b]) begin
            mem[word_adr_i][8*b +: 8] <= req_i.wdat[8*b +: 8];
          end
        end
      end else begin
        rdat_q <= mem[word_adr_i];
      end
    end
  end

  assign ack        = (state_q == ST_ACK);
  assign rsp_o.ack  = ack;
  // zero outside the ack cycle so the OR mux stays clean
  assign rsp_o.rdat = ack ? rdat_q : '0;

  // one ack per request, even when cyc is held longer
  assert property (@(posedge sysclock) disable iff (!rst_n)
                   rsp_o.ack |=> !rsp_o.ack)
    else $error("mem_bank: ack high two cycles in a row");

  // decoder must gate the select with cyc
  assert property (@(posedge sysclock) disable iff (!rst_n)
                   sel_i |-> req_i.cyc)
    else $error("mem_bank: select without cyc");

endmodule

/* src/addr_decoder.sv */
`timescale 1ns/1ps

module addr_decoder import soc_pkg::*; (
  input  bus_req_t               req_i,
  output csel_t                  csel_o,
  output logic [NUM_BANKS-1:0]   bank_sel_o,
  output word_adr_t              word_adr_o
);

  // byte offset relative to bank 0
  addr_t offset;
  logic  in_map;
  logic [NUM_BANKS-1:0] window_sel;

  assign offset = req_i.adr - BANK_BASE;

  // below the base the subtraction wraps, so check both ends
  assign in_map = (req_i.adr >= BANK_BASE) && (offset < MAP_SPAN);

  // chipselect 1..NUM_BANKS names bank 0..NUM_BANKS-1
  always_comb begin
    csel_o = CSEL_NONE;
    if (in_map) begin
      csel_o = csel_t'(offset / BANK_STRIDE) + csel_t'(1);
    end
  end

  // one-hot bank strobe, only while the master drives cyc
  always_comb begin
    bank_sel_o = '0;
    for (int i = 0; i < NUM_BANKS; i++) begin
      bank_sel_o[i] = req_i.cyc && (csel_o == csel_t'(i + 1));
    end
  end

  // word offset inside a bank, same for every bank
  assign word_adr_o = req_i.adr[WORD_LSB +: WORD_ADR_W];

  // strobe expected from the plain bank address windows
  always_comb begin
    for (int i = 0; i < NUM_BANKS; i++) begin
      window_sel[i] = req_i.cyc &&
                      (req_i.adr >= BANK_BASE + addr_t'(i) * BANK_STRIDE) &&
                      (req_i.adr <  BANK_BASE + addr_t'(i + 1) * BANK_STRIDE);
    end
  end

  // strobes match the bank windows, never two at once
  always_comb begin
    assert final ($onehot0(bank_sel_o) && (bank_sel_o == window_sel))
      else $error("addr_decoder: bank select wrong for address %h", req_i.adr);
  end

endmodule

/* src/soc_pkg.sv */
package soc_pkg;

  // basic bus widths
  localparam int unsigned ADDR_W     = 32;
  localparam int unsigned DATA_W     = 32;
  localparam int unsigned BE_W       = DATA_W / 8;
  localparam int unsigned CSEL_W     = 4;
  localparam int unsigned WORD_ADR_W = 9;
  // byte address bit where the word offset starts
  localparam int unsigned WORD_LSB   = 2;

  typedef logic [ADDR_W-1:0]     addr_t;
  typedef logic [DATA_W-1:0]     data_t;
  typedef logic [BE_W-1:0]       be_t;
  typedef logic [CSEL_W-1:0]     csel_t;
  typedef logic [WORD_ADR_W-1:0] word_adr_t;

  // onboard memory map
  localparam int unsigned NUM_BANKS   = 4;
  localparam int unsigned BANK_WORDS  = 512;
  localparam addr_t       BANK_BASE   = 32'h0080_0000;
  localparam addr_t       BANK_STRIDE = 32'h0000_0800;
  // total bytes covered by all banks
  localparam addr_t       MAP_SPAN    = addr_t'(NUM_BANKS) * BANK_STRIDE;

  // chipselect for addresses outside every bank
  localparam csel_t       CSEL_NONE   = '0;

  // master request, held until ack
  typedef struct packed {
    logic  cyc;
    logic  we;
    addr_t adr;
    data_t wdat;
    be_t   be;
  } bus_req_t;

  // answer back to the master
  typedef struct packed {
    logic  ack;
    logic  err;
    data_t rdat;
  } bus_rsp_t;

  // single bank answer
  typedef struct packed {
    logic  ack;
    data_t rdat;
  } bank_rsp_t;

endpackage
